// File: src.f
verilog/eth_frame_pkg.sv
verilog/icmp_tx_pkg.sv
verilog/eth_crc32.sv
verilog/icmp_hdr_builder.sv
verilog/gmii_frame_sequencer.sv
verilog/icmp_tx_top.sv
verification/icmp_tx_checker.sv
verification/tb_icmp_tx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_icmp_tx
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_icmp_tx.sv
module tb_icmp_tx;
    timeunit 1ns;
    timeprecision 1ps;
    import eth_frame_pkg::*;
    import icmp_tx_pkg::*;

    localparam mac_addr_t BOARD_MAC = 48'h00_11_22_33_44_55;
    localparam ip_addr_t  BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd123};

    logic        clk;
    logic        rst_n;
    logic        start;
    tx_request_t req;
    byte_t       payload_data;
    logic        busy;
    logic        payload_rd;
    logic        gmii_tx_en;
    byte_t       gmii_txd;
    logic        tx_done;

    byte_t  cap [128];          // Bytes seen while gmii_tx_en is high
    byte_t  exp_payload [64];
    int     cap_len;
    int     rd_idx;
    int     errors;
    int     n_pass;
    int     n_fail;
    integer seed;

    icmp_tx_top #(.board_mac(BOARD_MAC), .board_ip(BOARD_IP)) dut0 (.*);

    icmp_tx_checker #(.board_mac(BOARD_MAC), .board_ip(BOARD_IP)) checker0 (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Payload source with one cycle of read latency
    always @(posedge clk) begin
        if (payload_rd) begin
            #2;
            payload_data = exp_payload[rd_idx];
            rd_idx       = rd_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (gmii_tx_en && cap_len < 128) begin
            cap[cap_len] <= gmii_txd;
            cap_len      <= cap_len + 1;
        end else if (tx_done) begin
            cap_len <= 0;  // Checker has read the frame at this edge
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic new_request(input int len);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < len; i++)
            exp_payload[i] = 8'($random(seed));
        for (int i = 0; i < len; i += 2)
            sum += 32'({exp_payload[i], (i + 1 < len) ? exp_payload[i + 1] : 8'h00});
        req.dest_mac    = {16'($random(seed)), 32'($random(seed))};
        req.dest_ip     = 32'($random(seed));
        req.icmp_id     = 16'($random(seed));
        req.icmp_seq    = 16'($random(seed));
        req.payload_len = len_t'(len);
        req.payload_sum = sum;
        rd_idx          = 0;
    endtask

    task automatic launch_frame(input int len);
        @(posedge clk);
        #2;
        new_request(len);
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_tx_done(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < 400 && !ok; i++) begin
            @(negedge clk);
            ok = tx_done;
        end
        if (!ok) begin
            $display("timeout, tx_done did not arrive within 400 cycles");
        end else begin
            @(posedge clk);  // Frame is checked on this edge
            #2;
        end
    endtask

    task automatic wait_tx_start(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < 20 && !ok; i++) begin
            @(negedge clk);
            ok = gmii_tx_en;
        end
        if (!ok)
            $display("timeout, gmii_tx_en did not rise within 20 cycles");
    endtask

    task automatic send_frame(input int len, output bit ok);
        launch_frame(len);
        wait_tx_done(ok);
    endtask

    task automatic end_test(input string name, input int err_before, input bit ok);
        if (ok && errors == err_before) begin
            n_pass++;
            $display("test %s passed", name);
        end else begin
            n_fail++;
            $display("test %s failed", name);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        bit ok;
        bit ok_all;
        int err0;
        int lens [4] = '{1, 17, 19, 63};
        seed         = 6;
        start        = 1'b0;
        req          = '0;
        payload_data = '0;
        rst_n        = 1'b0;
        cap_len      = 0;
        rd_idx       = 0;
        n_pass       = 0;
        n_fail       = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        err0 = errors;
        send_frame(18, ok);
        end_test("minimum payload", err0, ok);
        err0 = errors;
        send_frame(5, ok);
        end_test("short payload with padding", err0, ok);
        err0 = errors;
        send_frame(40, ok);
        end_test("long payload", err0, ok);
        err0 = errors;
        send_frame(0, ok);
        end_test("empty payload", err0, ok);

        err0   = errors;
        ok_all = 1'b1;
        foreach (lens[i]) begin
            send_frame(lens[i], ok);
            ok_all &= ok;
        end
        end_test("odd payload lengths", err0, ok_all);

        // Second start lands mid frame
        err0 = errors;
        launch_frame(24);
        wait_tx_start(ok);
        if (ok) begin
            @(posedge clk);
            #2;
            start = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
            wait_tx_done(ok);
        end
        repeat (30) @(posedge clk);  // Room for a stray frame
        end_test("start while busy", err0, ok);

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: verification/icmp_tx_checker.sv
module icmp_tx_checker #(
    parameter eth_frame_pkg::mac_addr_t board_mac = 48'h00_11_22_33_44_55,
    parameter eth_frame_pkg::ip_addr_t  board_ip  = {8'd192, 8'd168, 8'd1, 8'd123}
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     busy,
    input  logic                     payload_rd,
    input  logic                     gmii_tx_en,
    input  logic                     tx_done,
    input  icmp_tx_pkg::tx_request_t req,
    input  eth_frame_pkg::byte_t     cap [128],
    input  int                       cap_len,
    input  eth_frame_pkg::byte_t     exp_payload [64],
    output int                       errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import eth_frame_pkg::*;

    logic    prev_en;
    logic    prev_done;
    logic    in_flight;  // Accepted request not yet finished
    word16_t ip_id;      // Identification the current frame should carry
    int      cyc;
    int      acc_cyc;
    int      rd_cnt;

    initial errors = 0;

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("error %s expected 0x%h got 0x%h", name, exp, got);
        errors++;
    endtask

    task automatic report_fault(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_byte(input int idx, input byte_t exp);
        assert (cap[idx] == exp)
            else report_value($sformatf("gmii_txd byte %0d", idx), 32'(exp), 32'(cap[idx]));
    endtask

    // Ones' complement sum with two end-around carries
    function automatic word16_t fold_sum(input logic [31:0] s);
        logic [31:0] t;
        t = 32'(s[31:16]) + 32'(s[15:0]);
        t = 32'(t[31:16]) + 32'(t[15:0]);
        return t[15:0];
    endfunction

    // Bitwise Ethernet CRC over cap[first..last]
    function automatic logic [31:0] crc_over(input int first, input int last);
        logic [31:0] c;
        logic        fb;
        c = '1;
        for (int i = first; i <= last; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ cap[i][b];
                c  = {1'b0, c[31:1]} ^ (fb ? 32'hedb8_8320 : 32'h0);
            end
        end
        return c;
    endfunction

    // ------------------------------
    // Whole frame against the rules
    // ------------------------------
    task automatic verify_frame();
        int           n;
        int           plen;
        logic [159:0] ip_exp;
        logic [31:0]  idseq;
        logic [31:0]  sum;
        logic [31:0]  fcs;
        n     = int'(req.payload_len);
        plen  = (n < MIN_PAYLOAD_LEN) ? MIN_PAYLOAD_LEN : n;
        idseq = {req.icmp_id, req.icmp_seq};
        assert (cap_len == PREAMBLE_LEN + ETH_HDR_LEN + IP_ICMP_HDR_LEN + plen + FCS_LEN)
            else report_value("gmii_tx_en length", 32'(54 + plen), 32'(cap_len));
        for (int i = 0; i < 8; i++)
            check_byte(i, (i == 7) ? SFD_BYTE : PREAMBLE_BYTE);
        for (int i = 0; i < 6; i++) begin
            check_byte(8 + i, req.dest_mac[47 - 8 * i -: 8]);
            check_byte(14 + i, board_mac[47 - 8 * i -: 8]);
        end
        check_byte(20, ETH_TYPE_IPV4[15:8]);
        check_byte(21, ETH_TYPE_IPV4[7:0]);
        // IPv4 starts at 22 and its checksum bytes are covered by the sum below
        ip_exp = {8'h45, 8'h00, 16'(n + 28), ip_id, IP_FLAGS_DF, IP_TTL, IP_PROTO_ICMP,
                  16'h0000, board_ip, req.dest_ip};
        for (int i = 0; i < 20; i++) begin
            if (i != 10 && i != 11)
                check_byte(22 + i, ip_exp[159 - 8 * i -: 8]);
        end
        sum = '0;
        for (int i = 0; i < 10; i++)
            sum += 32'({cap[22 + 2 * i], cap[23 + 2 * i]});
        assert (fold_sum(sum) == 16'hffff)
            else report_value("gmii_txd ipv4 checksum", 32'hffff, 32'(fold_sum(sum)));
        check_byte(42, ICMP_ECHO_REPLY);
        check_byte(43, 8'h00);
        for (int i = 0; i < 4; i++)
            check_byte(46 + i, idseq[31 - 8 * i -: 8]);
        sum = '0;
        for (int i = 0; i < 4; i++)
            sum += 32'({cap[42 + 2 * i], cap[43 + 2 * i]});
        for (int i = 0; i < n; i += 2)
            sum += 32'({cap[50 + i], (i + 1 < n) ? cap[51 + i] : 8'h00});  // Odd tail padded
        assert (fold_sum(sum) == 16'hffff)
            else report_value("gmii_txd icmp checksum", 32'hffff, 32'(fold_sum(sum)));
        for (int i = 0; i < plen; i++)
            check_byte(50 + i, (i < n) ? exp_payload[i] : 8'h00);
        fcs = ~crc_over(8, 49 + plen);
        for (int k = 0; k < 4; k++)
            check_byte(50 + plen + k, fcs[8 * k +: 8]);  // Low byte first
        assert (rd_cnt == n) else report_value("payload_rd count", 32'(n), 32'(rd_cnt));
    endtask

    // ------------------------------
    // Handshake and timing
    // ------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_en   <= 1'b0;
            prev_done <= 1'b0;
            in_flight <= 1'b0;
            ip_id     <= '0;
            cyc       <= 0;
            acc_cyc   <= 0;
            rd_cnt    <= 0;
        end else begin
            cyc       <= cyc + 1;
            prev_en   <= gmii_tx_en;
            prev_done <= tx_done;
            if (payload_rd)
                rd_cnt <= rd_cnt + 1;
            // Owned from the cycle after acceptance until tx_done
            assert (busy == (in_flight && !tx_done))
                else report_value("busy", 32'(in_flight && !tx_done), 32'(busy));
            if (gmii_tx_en && !prev_en) begin
                assert (in_flight) else report_fault("frame sent without an accepted start");
                assert (cyc - acc_cyc == 5)
                    else report_value("gmii_tx_en latency", 32'd5, 32'(cyc - acc_cyc));
            end
            if (prev_en && !gmii_tx_en)
                assert (tx_done) else report_fault("no tx_done after the last FCS byte");
            if (tx_done) begin
                assert (!prev_done && prev_en && !gmii_tx_en)
                    else report_fault("tx_done is not one pulse right after the frame");
                verify_frame();
                rd_cnt    <= 0;
                in_flight <= 1'b0;
            end
            if (start && !busy) begin
                in_flight <= 1'b1;
                acc_cyc   <= cyc;
                ip_id     <= ip_id + 16'd1;
            end
        end
    end

endmodule

// File: verilog/icmp_tx_top.sv
module icmp_tx_top #(
    parameter eth_frame_pkg::mac_addr_t board_mac = 48'h00_11_22_33_44_55,
    parameter eth_frame_pkg::ip_addr_t  board_ip  = {8'd192, 8'd168, 8'd1, 8'd123}
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  icmp_tx_pkg::tx_request_t req,
    input  eth_frame_pkg::byte_t     payload_data,
    output logic                     busy,
    output logic                     payload_rd,
    output logic                     gmii_tx_en,
    output eth_frame_pkg::byte_t     gmii_txd,
    output logic                     tx_done
);
    import eth_frame_pkg::*;
    import icmp_tx_pkg::*;

    frame_hdr_t  hdr;
    logic        hdr_valid;
    logic        frame_done;

    // CRC hookup
    logic        crc_init;
    logic        crc_en;
    byte_t       crc_byte;
    logic [31:0] crc_value;

    icmp_hdr_builder #(
        .board_mac (board_mac),
        .board_ip  (board_ip)
    ) hdr_builder0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .req        (req),
        .frame_done (frame_done),
        .busy       (busy),
        .hdr        (hdr),
        .hdr_valid  (hdr_valid)
    );

    gmii_frame_sequencer frame_seq0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .payload_data (payload_data),
        .crc_value    (crc_value),
        .payload_rd   (payload_rd),
        .gmii_tx_en   (gmii_tx_en),
        .gmii_txd     (gmii_txd),
        .crc_init     (crc_init),
        .crc_en       (crc_en),
        .crc_byte     (crc_byte),
        .frame_done   (frame_done),
        .tx_done      (tx_done)
    );

    eth_crc32 crc0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .crc_init  (crc_init),
        .crc_en    (crc_en),
        .crc_byte  (crc_byte),
        .crc_value (crc_value)
    );

endmodule

// File: verilog/gmii_frame_sequencer.sv
module gmii_frame_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  icmp_tx_pkg::frame_hdr_t hdr,
    input  logic                    hdr_valid,
    input  eth_frame_pkg::byte_t    payload_data,
    input  logic [31:0]             crc_value,
    output logic                    payload_rd,
    output logic                    gmii_tx_en,
    output eth_frame_pkg::byte_t    gmii_txd,
    output logic                    crc_init,
    output logic                    crc_en,
    output eth_frame_pkg::byte_t    crc_byte,
    output logic                    frame_done,
    output logic                    tx_done
);
    import eth_frame_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_eth_hdr,
        st_ip_hdr,
        st_payload,
        st_pad,
        st_fcs
    } state_t;

    state_t                   state;
    len_t                     cnt;       // Byte index inside the current segment
    len_t                     len;
    byte_t                    tx_byte;
    logic [ETH_HDR_LEN*8-1:0] eth_vec;
    logic                     done_q;

    assign len     = hdr.payload_len;
    assign eth_vec = {hdr.dest_mac, hdr.src_mac, ETH_TYPE_IPV4};

    // ------------------------------
    // Segment sequencing
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            cnt    <= cnt + len_t'(1);
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (hdr_valid)
                        state <= st_preamble;
                end
                st_preamble: begin
                    if (cnt == len_t'(PREAMBLE_LEN - 1)) begin
                        state <= st_eth_hdr;
                        cnt   <= '0;
                    end
                end
                st_eth_hdr: begin
                    if (cnt == len_t'(ETH_HDR_LEN - 1)) begin
                        state <= st_ip_hdr;
                        cnt   <= '0;
                    end
                end
                st_ip_hdr: begin
                    if (cnt == len_t'(IP_ICMP_HDR_LEN - 1)) begin
                        state <= (len == '0) ? st_pad : st_payload;  // Empty echo pads only
                        cnt   <= '0;
                    end
                end
                st_payload: begin
                    if (cnt == len - len_t'(1)) begin
                        // Short payload keeps counting into the pad
                        if (len < len_t'(MIN_PAYLOAD_LEN)) begin
                            state <= st_pad;
                        end else begin
                            state <= st_fcs;
                            cnt   <= '0;
                        end
                    end
                end
                st_pad: begin
                    if (cnt == len_t'(MIN_PAYLOAD_LEN - 1)) begin
                        state <= st_fcs;
                        cnt   <= '0;
                    end
                end
                st_fcs: begin
                    if (cnt == len_t'(FCS_LEN - 1)) begin
                        state  <= st_idle;
                        cnt    <= '0;
                        done_q <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ------------------------------
    // Byte selection
    // ------------------------------
    always_comb begin
        case (state)
            st_preamble: tx_byte = (cnt == len_t'(PREAMBLE_LEN - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
            st_eth_hdr:  tx_byte = eth_vec[(ETH_HDR_LEN - 1 - int'(cnt)) * 8 +: 8];
            st_ip_hdr:   tx_byte = hdr.ip_icmp[(IP_ICMP_HDR_LEN - 1 - int'(cnt)) * 8 +: 8];
            st_payload:  tx_byte = payload_data;
            // Reflected register is already in wire bit order, low byte goes first
            st_fcs:      tx_byte = ~crc_value[int'(cnt[1:0]) * 8 +: 8];
            default:     tx_byte = '0;  // Idle and pad
        endcase
    end

    assign gmii_tx_en = (state != st_idle);
    assign gmii_txd   = tx_byte;

    // CRC covers destination MAC through the pad
    assign crc_init = hdr_valid & (state == st_idle);
    assign crc_en   = (state == st_eth_hdr) || (state == st_ip_hdr) ||
                      (state == st_payload) || (state == st_pad);
    assign crc_byte = tx_byte;

    // Source answers one cycle after the read
    assign payload_rd = ((state == st_ip_hdr) && (cnt == len_t'(IP_ICMP_HDR_LEN - 1))
                         && (len != '0))
                     || ((state == st_payload) && (cnt + len_t'(1) < len));

    assign frame_done = done_q;
    assign tx_done    = done_q;

    a_rd_then_payload: assert property (@(posedge clk) disable iff (!rst_n)
        payload_rd |=> (state == st_payload));

    // Enable drops only once the frame is complete
    a_no_gap: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii_tx_en) |-> frame_done);

endmodule

// File: verilog/icmp_hdr_builder.sv
module icmp_hdr_builder #(
    parameter eth_frame_pkg::mac_addr_t board_mac = 48'h00_11_22_33_44_55,
    parameter eth_frame_pkg::ip_addr_t  board_ip  = {8'd192, 8'd168, 8'd1, 8'd123}
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  icmp_tx_pkg::tx_request_t req,
    input  logic                     frame_done,
    output logic                     busy,
    output icmp_tx_pkg::frame_hdr_t  hdr,
    output logic                     hdr_valid
);
    import eth_frame_pkg::*;
    import icmp_tx_pkg::*;

    localparam byte_t IP_VER_IHL = 8'h45;  // IPv4, five 32 bit words

    typedef enum logic [2:0] {
        st_idle,
        st_capture,
        st_fold_ip,
        st_fold_icmp,
        st_ready
    } state_t;

    state_t      state;
    tx_request_t req_q;
    word16_t     ip_id;      // Identification, one step per accepted request
    logic [31:0] ip_sum;
    logic [31:0] icmp_sum;
    len_t        total_len;
    logic        accept;

    // One end-around-carry step
    function automatic logic [31:0] fold(input logic [31:0] s);
        return 32'(s[31:16]) + 32'(s[15:0]);
    endfunction

    // Free again in the cycle the sequencer reports the frame sent
    assign busy      = (state != st_idle) & ~frame_done;
    assign accept    = start & ~busy;
    assign total_len = req_q.payload_len + len_t'(IP_ICMP_HDR_LEN);

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            ip_id     <= '0;
            hdr_valid <= 1'b0;
        end else begin
            hdr_valid <= 1'b0;
            if (accept) begin
                state <= st_capture;
                ip_id <= ip_id + 16'd1;  // First frame goes out with 1
            end else begin
                case (state)
                    st_capture:   state <= st_fold_ip;
                    st_fold_ip:   state <= st_fold_icmp;
                    st_fold_icmp: begin
                        state     <= st_ready;
                        hdr_valid <= 1'b1;
                    end
                    st_ready: begin
                        if (frame_done)
                            state <= st_idle;
                    end
                    default:      state <= st_idle;
                endcase
            end
        end
    end

    // ------------------------------
    // Checksums
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept)
            req_q <= req;
        case (state)
            st_capture: begin
                // Checksum field counts as zero
                ip_sum   <= 32'({IP_VER_IHL, 8'h00}) + 32'(total_len) + 32'(ip_id)
                          + 32'(IP_FLAGS_DF) + 32'({IP_TTL, IP_PROTO_ICMP})
                          + 32'(board_ip[31:16]) + 32'(board_ip[15:0])
                          + 32'(req_q.dest_ip[31:16]) + 32'(req_q.dest_ip[15:0]);
                icmp_sum <= 32'({ICMP_ECHO_REPLY, 8'h00}) + 32'(req_q.icmp_id)
                          + 32'(req_q.icmp_seq) + req_q.payload_sum;
            end
            st_fold_ip:   ip_sum   <= fold(fold(ip_sum));
            st_fold_icmp: icmp_sum <= fold(fold(icmp_sum));
            default: ;
        endcase
    end

    // Header image, stable from hdr_valid until the next accepted request
    always_comb begin
        hdr.dest_mac    = req_q.dest_mac;
        hdr.src_mac     = board_mac;
        hdr.payload_len = req_q.payload_len;
        hdr.ip_icmp     = {IP_VER_IHL, 8'h00, total_len,
                           ip_id, IP_FLAGS_DF,
                           IP_TTL, IP_PROTO_ICMP, ~ip_sum[15:0],
                           board_ip,
                           req_q.dest_ip,
                           ICMP_ECHO_REPLY, 8'h00, ~icmp_sum[15:0],  // ICMP type, code
                           req_q.icmp_id, req_q.icmp_seq};
    end

    // Header is handed over only while a frame is owned
    a_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_valid |-> busy);

    a_hdr_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##4 hdr_valid);

endmodule

// File: verilog/eth_crc32.sv
module eth_crc32 (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 crc_init,
    input  logic                 crc_en,
    input  eth_frame_pkg::byte_t crc_byte,
    output logic [31:0]          crc_value
);
    import eth_frame_pkg::*;

    localparam logic [31:0] CRC_POLY = 32'hedb8_8320;  // Reflected 0x04C11DB7

    // ------------------------------
    // One byte, LSB first
    // ------------------------------
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0])
                c = (c >> 1) ^ CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_value <= '1;
        end else if (crc_init) begin
            crc_value <= '1;  // Seed before the first header byte
        end else if (crc_en) begin
            crc_value <= crc_step(crc_value, crc_byte);
        end
    end

endmodule

// File: verilog/icmp_tx_pkg.sv
package icmp_tx_pkg;

    import eth_frame_pkg::*;

    // ------------------------------
    // Echo reply request
    // ------------------------------
    // Presented with the start pulse, sampled once when accepted
    typedef struct packed {
        mac_addr_t   dest_mac;
        ip_addr_t    dest_ip;
        word16_t     icmp_id;
        word16_t     icmp_seq;
        len_t        payload_len;   // Payload bytes, padding not included
        logic [31:0] payload_sum;   // Running sum of the payload's 16 bit words
    } tx_request_t;

    // ------------------------------
    // Finished frame header
    // ------------------------------
    // IPv4 and ICMP headers with checksums filled in, MSB is the first byte on the wire
    typedef struct packed {
        mac_addr_t                      dest_mac;
        mac_addr_t                      src_mac;
        logic [IP_ICMP_HDR_LEN*8-1:0]   ip_icmp;
        len_t                           payload_len;
    } frame_hdr_t;

endpackage

// File: verilog/eth_frame_pkg.sv
package eth_frame_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------
    typedef logic [7:0]  byte_t;      // One GMII octet
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] word16_t;    // Checksum word
    typedef logic [15:0] len_t;       // Byte count

    // ------------------------------
    // Ethernet framing
    // ------------------------------
    localparam word16_t ETH_TYPE_IPV4 = 16'h0800;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;

    // Segment lengths in bytes
    localparam int PREAMBLE_LEN    = 8;   // Seven 0x55 plus the SFD
    localparam int ETH_HDR_LEN     = 14;
    localparam int IP_ICMP_HDR_LEN = 28;  // 20 byte IPv4 + 8 byte ICMP
    localparam int FCS_LEN         = 4;

    // 46 byte minimum Ethernet payload less the 28 header bytes
    localparam int MIN_PAYLOAD_LEN = 18;

    // ------------------------------
    // IPv4 header constants
    // ------------------------------
    localparam byte_t   IP_TTL        = 8'h80;
    localparam byte_t   IP_PROTO_ICMP = 8'd1;
    localparam word16_t IP_FLAGS_DF   = 16'h4000;  // Don't fragment, offset 0

    // ------------------------------
    // ICMP
    // ------------------------------
    localparam byte_t ICMP_ECHO_REPLY = 8'd0;

endpackage
